// File: msg_consts.svh
`ifndef MSG_CONSTS_SVH
`define MSG_CONSTS_SVH

// Fabric side widths
`define MSG_ADDR_W     32
`define MSG_DATA_W     64
`define MSG_NUM_W      15
`define MSG_STAT_W     10
`define MSG_TAG_W      4

// Load flow control
`define MSG_MAX_OUT    8

// Byte step between consecutive messages
`define MSG_STRIDE     8

// Register map
`define MSG_REG_IDX_W  3
`define MSG_REG_CTRL     3'd0
`define MSG_REG_ST_BASE  3'd1
`define MSG_REG_LD_BASE  3'd2
`define MSG_REG_STATUS   3'd3
`define MSG_REG_PASS     3'd4
`define MSG_REG_FAIL     3'd5

`endif

// File: msg_pkg.sv
`default_nettype none

`include "msg_consts.svh"

package msg_pkg;

  // Host side address and payload
  typedef logic [`MSG_ADDR_W-1:0]    msg_addr_t;
  typedef logic [`MSG_DATA_W-1:0]    msg_data_t;

  // Run length and statistics
  typedef logic [`MSG_NUM_W-1:0]     msg_num_t;
  typedef logic [`MSG_STAT_W-1:0]    msg_stat_t;

  // Load tag, wraps every 16 messages
  typedef logic [`MSG_TAG_W-1:0]     msg_tag_t;

  // Register bank access
  typedef logic [`MSG_REG_IDX_W-1:0] reg_idx_t;
  typedef logic [31:0]               reg_word_t;

  // Payload carried by the message at a given host address
  // Address in the upper half, its inverse in the lower half
  function automatic msg_data_t msg_pattern(input msg_addr_t addr);
    msg_pattern = {addr, ~addr};
  endfunction

endpackage

`default_nettype wire

// File: msg_throttle.sv
`timescale 1ns/1ns
`default_nettype none

module msg_throttle #(
  parameter logic [31:0] SEED = 32'hb105f00d
) (
  input  logic       fabric_clk,
  input  logic       arst_n,

  // Stall level, 0 never stalls, 7 stalls seven cycles in eight
  input  logic [2:0] back_pres,
  input  logic       halt,

  output logic       issue_en
);

  logic [31:0] lfsr;
  logic        feedback;

  // Taps 32, 22, 2, 1 for a maximal length sequence
  assign feedback = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];

  // Free running, one step per cycle
  always_ff @(posedge fabric_clk or negedge arst_n) begin
    if (!arst_n) begin
      lfsr <= SEED;
    end else begin
      lfsr <= {lfsr[30:0], feedback};
    end
  end

  // Halt wins over the random pacing
  assign issue_en = !halt && (lfsr[2:0] >= back_pres);

endmodule

`default_nettype wire

// File: msg_regs.sv
`timescale 1ns/1ns
`default_nettype none

`include "msg_consts.svh"

module msg_regs
  import msg_pkg::*;
(
  input  logic      fabric_clk,
  input  logic      arst_n,

  // Register access strobes
  input  logic      reg_wr,
  input  reg_idx_t  reg_idx,
  input  reg_word_t reg_wdata,
  output reg_word_t reg_rdata,

  // Engine control
  output logic      st_start,
  output logic      ld_start,
  output msg_num_t  st_count,
  output msg_num_t  ld_count,
  output msg_addr_t st_base,
  output msg_addr_t ld_base,

  // Engine status
  input  logic      st_done,
  input  logic      ld_done,
  input  logic      order_error,
  input  msg_stat_t pass_count,
  input  msg_stat_t fail_count
);

  logic ctrl_wr;

  assign ctrl_wr = reg_wr && (reg_idx == `MSG_REG_CTRL);

  // Control word, counts and base addresses
  always_ff @(posedge fabric_clk or negedge arst_n) begin
    if (!arst_n) begin
      st_start <= 1'b0;
      ld_start <= 1'b0;
      st_count <= '0;
      ld_count <= '0;
      st_base  <= '0;
      ld_base  <= '0;
    end else begin
      // Start bits only live for one cycle
      st_start <= ctrl_wr && reg_wdata[0];
      ld_start <= ctrl_wr && reg_wdata[16];
      if (ctrl_wr) begin
        st_count <= reg_wdata[15:1];
        ld_count <= reg_wdata[31:17];
      end
      if (reg_wr && (reg_idx == `MSG_REG_ST_BASE)) begin
        st_base <= reg_wdata;
      end
      if (reg_wr && (reg_idx == `MSG_REG_LD_BASE)) begin
        ld_base <= reg_wdata;
      end
    end
  end

  // Readback mux, sampled every cycle
  always_ff @(posedge fabric_clk or negedge arst_n) begin
    if (!arst_n) begin
      reg_rdata <= '0;
    end else begin
      case (reg_idx)
        `MSG_REG_CTRL: begin
          // Start bits read as zero
          reg_rdata <= {ld_count, 1'b0, st_count, 1'b0};
        end
        `MSG_REG_ST_BASE: begin
          reg_rdata <= st_base;
        end
        `MSG_REG_LD_BASE: begin
          reg_rdata <= ld_base;
        end
        `MSG_REG_STATUS: begin
          reg_rdata <= {29'd0, order_error, ld_done, st_done};
        end
        `MSG_REG_PASS: begin
          reg_rdata <= {{(32-`MSG_STAT_W){1'b0}}, pass_count};
        end
        `MSG_REG_FAIL: begin
          reg_rdata <= {{(32-`MSG_STAT_W){1'b0}}, fail_count};
        end
        default: begin
          reg_rdata <= '0;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: msgst_engine.sv
`timescale 1ns/1ns
`default_nettype none

`include "msg_consts.svh"

module msgst_engine
  import msg_pkg::*;
(
  input  logic      fabric_clk,
  input  logic      arst_n,

  input  logic      st_start,
  input  msg_num_t  st_count,
  input  msg_addr_t st_base,
  input  logic      issue_en,

  // Store message strobe towards the fabric
  output logic      st_valid,
  output msg_addr_t st_addr,
  output msg_data_t st_data,
  output logic      st_done
);

  msg_num_t  remaining;
  msg_addr_t cur_addr;
  logic      busy;
  logic      issue;

  // A new start pulse takes priority over a pending issue
  assign issue = busy && issue_en && !st_start;

  always_ff @(posedge fabric_clk or negedge arst_n) begin
    if (!arst_n) begin
      busy      <= 1'b0;
      remaining <= '0;
      cur_addr  <= '0;
      st_valid  <= 1'b0;
      st_done   <= 1'b0;
    end else begin
      st_valid <= issue;
      if (st_start) begin
        busy      <= (st_count != '0);
        remaining <= st_count;
        cur_addr  <= st_base;
        // Empty run finishes at once
        st_done   <= (st_count == '0);
      end else begin
        if (issue) begin
          remaining <= remaining - 1'b1;
          cur_addr  <= cur_addr + msg_addr_t'(`MSG_STRIDE);
          busy      <= (remaining != msg_num_t'(1));
        end
        // busy already dropped, so this strobe was the last one
        if (st_valid && !busy) begin
          st_done <= 1'b1;
        end
      end
    end
  end

  // Message address and payload
  always_ff @(posedge fabric_clk) begin
    if (issue) begin
      st_addr <= cur_addr;
      st_data <= msg_pattern(cur_addr);
    end
  end

endmodule

`default_nettype wire

// File: msgld_engine.sv
`timescale 1ns/1ns
`default_nettype none

`include "msg_consts.svh"

module msgld_engine
  import msg_pkg::*;
(
  input  logic      fabric_clk,
  input  logic      arst_n,

  input  logic      ld_start,
  input  msg_num_t  ld_count,
  input  msg_addr_t ld_base,
  input  logic      issue_en,

  // Load request towards the fabric
  output logic      ld_valid,
  output msg_addr_t ld_addr,
  output msg_tag_t  ld_tag,

  // Load response, in issue order
  input  logic      rsp_valid,
  input  msg_data_t rsp_data,
  input  msg_tag_t  rsp_tag,

  output logic      ld_done,
  output logic      order_error,
  output msg_stat_t pass_count,
  output msg_stat_t fail_count
);

  localparam int OUT_W = $clog2(`MSG_MAX_OUT + 1);

  msg_num_t         issue_left;
  msg_num_t         rsp_left;
  msg_addr_t        issue_addr;
  msg_addr_t        exp_addr;
  msg_tag_t         issue_tag;
  msg_tag_t         exp_tag;
  logic [OUT_W-1:0] outstanding;
  logic             issue;
  logic             rsp_take;

  // Hold off issue while the outstanding limit is reached
  assign issue = (issue_left != '0) && issue_en && !ld_start &&
                 (outstanding < OUT_W'(`MSG_MAX_OUT));

  // Stray responses outside a run are dropped
  assign rsp_take = rsp_valid && (rsp_left != '0) && !ld_start;

  // Request sequencer
  always_ff @(posedge fabric_clk or negedge arst_n) begin
    if (!arst_n) begin
      issue_left <= '0;
      issue_addr <= '0;
      issue_tag  <= '0;
      ld_valid   <= 1'b0;
    end else begin
      ld_valid <= issue;
      if (ld_start) begin
        issue_left <= ld_count;
        issue_addr <= ld_base;
        issue_tag  <= '0;
      end else if (issue) begin
        issue_left <= issue_left - 1'b1;
        issue_addr <= issue_addr + msg_addr_t'(`MSG_STRIDE);
        issue_tag  <= issue_tag + 1'b1;
      end
    end
  end

  always_ff @(posedge fabric_clk) begin
    if (issue) begin
      ld_addr <= issue_addr;
      ld_tag  <= issue_tag;
    end
  end

  // Loads in flight
  always_ff @(posedge fabric_clk or negedge arst_n) begin
    if (!arst_n) begin
      outstanding <= '0;
    end else if (ld_start) begin
      outstanding <= '0;
    end else if (issue && !rsp_take) begin
      outstanding <= outstanding + 1'b1;
    end else if (!issue && rsp_take) begin
      outstanding <= outstanding - 1'b1;
    end
  end

  // Response checker, expected address follows the expected tag sequence
  always_ff @(posedge fabric_clk or negedge arst_n) begin
    if (!arst_n) begin
      rsp_left    <= '0;
      exp_addr    <= '0;
      exp_tag     <= '0;
      ld_done     <= 1'b0;
      order_error <= 1'b0;
      pass_count  <= '0;
      fail_count  <= '0;
    end else if (ld_start) begin
      rsp_left    <= ld_count;
      exp_addr    <= ld_base;
      exp_tag     <= '0;
      ld_done     <= (ld_count == '0);
      order_error <= 1'b0;
      pass_count  <= '0;
      fail_count  <= '0;
    end else if (rsp_take) begin
      rsp_left <= rsp_left - 1'b1;
      exp_addr <= exp_addr + msg_addr_t'(`MSG_STRIDE);
      exp_tag  <= exp_tag + 1'b1;
      if (rsp_data == msg_pattern(exp_addr)) begin
        pass_count <= pass_count + 1'b1;
      end else begin
        fail_count <= fail_count + 1'b1;
      end
      // Sticky until the next start
      if (rsp_tag != exp_tag) begin
        order_error <= 1'b1;
      end
      if (rsp_left == msg_num_t'(1)) begin
        ld_done <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: msg_traffic_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "msg_consts.svh"

module msg_traffic_top
  import msg_pkg::*;
(
  input  logic       fabric_clk,
  input  logic       arst_n,

  // Register access
  input  logic       reg_wr,
  input  reg_idx_t   reg_idx,
  input  reg_word_t  reg_wdata,
  output reg_word_t  reg_rdata,

  // Throttle control
  input  logic [2:0] back_pres,
  input  logic       halt,

  // Store messages
  output logic       st_valid,
  output msg_addr_t  st_addr,
  output msg_data_t  st_data,

  // Load requests and responses
  output logic       ld_valid,
  output msg_addr_t  ld_addr,
  output msg_tag_t   ld_tag,
  input  logic       rsp_valid,
  input  msg_data_t  rsp_data,
  input  msg_tag_t   rsp_tag
);

  logic      st_start;
  logic      ld_start;
  msg_num_t  st_count;
  msg_num_t  ld_count;
  msg_addr_t st_base;
  msg_addr_t ld_base;
  logic      st_done;
  logic      ld_done;
  logic      order_error;
  msg_stat_t pass_count;
  msg_stat_t fail_count;
  logic      issue_en;

  msg_regs u_regs (
    .fabric_clk  (fabric_clk),
    .arst_n      (arst_n),
    .reg_wr      (reg_wr),
    .reg_idx     (reg_idx),
    .reg_wdata   (reg_wdata),
    .reg_rdata   (reg_rdata),
    .st_start    (st_start),
    .ld_start    (ld_start),
    .st_count    (st_count),
    .ld_count    (ld_count),
    .st_base     (st_base),
    .ld_base     (ld_base),
    .st_done     (st_done),
    .ld_done     (ld_done),
    .order_error (order_error),
    .pass_count  (pass_count),
    .fail_count  (fail_count)
  );

  msgst_engine u_msgst (
    .fabric_clk (fabric_clk),
    .arst_n     (arst_n),
    .st_start   (st_start),
    .st_count   (st_count),
    .st_base    (st_base),
    .issue_en   (issue_en),
    .st_valid   (st_valid),
    .st_addr    (st_addr),
    .st_data    (st_data),
    .st_done    (st_done)
  );

  msgld_engine u_msgld (
    .fabric_clk  (fabric_clk),
    .arst_n      (arst_n),
    .ld_start    (ld_start),
    .ld_count    (ld_count),
    .ld_base     (ld_base),
    .issue_en    (issue_en),
    .ld_valid    (ld_valid),
    .ld_addr     (ld_addr),
    .ld_tag      (ld_tag),
    .rsp_valid   (rsp_valid),
    .rsp_data    (rsp_data),
    .rsp_tag     (rsp_tag),
    .ld_done     (ld_done),
    .order_error (order_error),
    .pass_count  (pass_count),
    .fail_count  (fail_count)
  );

  // Shared pacing for both engines
  msg_throttle #(
    .SEED (32'hb105f00d)
  ) u_throttle (
    .fabric_clk (fabric_clk),
    .arst_n     (arst_n),
    .back_pres  (back_pres),
    .halt       (halt),
    .issue_en   (issue_en)
  );

endmodule

`default_nettype wire

// File: tb_msg_traffic.sv
`timescale 1ns/1ns
`default_nettype none

`include "msg_consts.svh"

module tb_msg_traffic;

  localparam int MAX_RUN  = 40;
  localparam int NUM_RUNS = 8;
  // Worst case per request under full back-pressure plus response delay
  localparam int CYCLE_LIMIT = NUM_RUNS * MAX_RUN * 64 + 2000;

  localparam int MODE_CLEAN   = 0;
  localparam int MODE_CORRUPT = 1;
  localparam int MODE_SWAP    = 2;

  logic        fabric_clk;
  logic        arst_n;
  logic        reg_wr;
  logic [2:0]  reg_idx;
  logic [31:0] reg_wdata;
  logic [31:0] reg_rdata;
  logic [2:0]  back_pres;
  logic        halt;
  logic        st_valid;
  logic [31:0] st_addr;
  logic [63:0] st_data;
  logic        ld_valid;
  logic [31:0] ld_addr;
  logic [3:0]  ld_tag;
  logic        rsp_valid;
  logic [63:0] rsp_data;
  logic [3:0]  rsp_tag;

  logic [31:0] lfsr_state;
  int          err_cnt;
  int          proto_err;
  int          cycles = 0;
  int          st_seen;
  int          ld_seen;
  logic [31:0] st_exp_addr;
  logic [31:0] ld_exp_addr;
  logic        halt_watch;

  // Fabric memory and pending loads
  logic [63:0] mem [logic [31:0]];
  logic [31:0] pend_addr [$];
  logic [3:0]  pend_tag [$];
  int          rsp_cnt;
  int          rsp_wait;
  int          rsp_mode;

  msg_traffic_top DUT (
    .fabric_clk (fabric_clk),
    .arst_n     (arst_n),
    .reg_wr     (reg_wr),
    .reg_idx    (reg_idx),
    .reg_wdata  (reg_wdata),
    .reg_rdata  (reg_rdata),
    .back_pres  (back_pres),
    .halt       (halt),
    .st_valid   (st_valid),
    .st_addr    (st_addr),
    .st_data    (st_data),
    .ld_valid   (ld_valid),
    .ld_addr    (ld_addr),
    .ld_tag     (ld_tag),
    .rsp_valid  (rsp_valid),
    .rsp_data   (rsp_data),
    .rsp_tag    (rsp_tag)
  );

  initial begin
    fabric_clk = 1'b0;
    forever begin
      #20 fabric_clk = ~fabric_clk;
    end
  end

  always @(posedge fabric_clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout: the run did not finish within %0d clock cycles", CYCLE_LIMIT);
      $display("TESTS FAILED");
      $finish;
    end
  end

  // Fibonacci LFSR stepped once per bit taken
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr_state[31] ^ lfsr_state[29] ^ lfsr_state[25] ^ lfsr_state[24];
      lfsr_state = {lfsr_state[30:0], fb};
      r = {r[30:0], fb};
    end
    return r;
  endfunction

  // Expected payload holds the address over its inverse
  function automatic logic [63:0] ref_pattern(input logic [31:0] addr);
    logic [31:0] low;
    low = addr ^ 32'hffff_ffff;
    return {addr, low};
  endfunction

  // Fabric model and store checker
  always @(negedge fabric_clk) begin
    if (halt_watch && (st_valid || ld_valid)) begin
      $display("Protocol error at %0t: a strobe appeared while halt was high", $time);
      proto_err++;
    end
    if (st_valid) begin
      if (st_addr !== st_exp_addr) begin
        $display("ERROR %0t: store %0d address %h, expected %h",
                 $time, st_seen, st_addr, st_exp_addr);
        err_cnt++;
      end
      if (st_data !== ref_pattern(st_exp_addr)) begin
        $display("ERROR %0t: store %0d data %h, expected %h",
                 $time, st_seen, st_data, ref_pattern(st_exp_addr));
        err_cnt++;
      end
      mem[st_addr] = st_data;
      st_exp_addr = st_exp_addr + 32'd8;
      st_seen++;
    end
    if (ld_valid) begin
      if (ld_addr !== ld_exp_addr) begin
        $display("ERROR %0t: load %0d address %h, expected %h",
                 $time, ld_seen, ld_addr, ld_exp_addr);
        err_cnt++;
      end
      if (ld_tag !== ld_seen[3:0]) begin
        $display("ERROR %0t: load %0d tag %h, expected %h", $time, ld_seen, ld_tag, ld_seen[3:0]);
        err_cnt++;
      end
      pend_addr.push_back(ld_addr);
      pend_tag.push_back(ld_tag);
      ld_exp_addr = ld_exp_addr + 32'd8;
      ld_seen++;
    end
    // Answer in issue order after a random delay
    rsp_valid = 1'b0;
    if (rsp_wait > 0) begin
      rsp_wait--;
    end else if (pend_addr.size() > 0) begin
      rsp_valid = 1'b1;
      rsp_data = mem.exists(pend_addr[0]) ? mem[pend_addr[0]] : '0;
      rsp_tag = pend_tag[0];
      if (rsp_mode == MODE_CORRUPT && rsp_cnt == 2) begin
        rsp_data = rsp_data ^ 64'h1;
      end
      // Tags of responses 1 and 2 trade places
      if (rsp_mode == MODE_SWAP && rsp_cnt == 1) begin
        rsp_tag = rsp_tag + 4'd1;
      end
      if (rsp_mode == MODE_SWAP && rsp_cnt == 2) begin
        rsp_tag = rsp_tag - 4'd1;
      end
      void'(pend_addr.pop_front());
      void'(pend_tag.pop_front());
      rsp_cnt++;
      rsp_wait = int'(take_bits(3));
    end
  end

  task automatic reg_write(input logic [2:0] idx, input logic [31:0] data);
    @(negedge fabric_clk);
    reg_wr = 1'b1;
    reg_idx = idx;
    reg_wdata = data;
    @(negedge fabric_clk);
    reg_wr = 1'b0;
  endtask

  // Read data is registered, so it is taken one cycle after the index
  task automatic reg_read(input logic [2:0] idx, output logic [31:0] data);
    @(negedge fabric_clk);
    reg_idx = idx;
    @(negedge fabric_clk);
    data = reg_rdata;
  endtask

  task automatic check_reg(input logic [2:0] idx, input logic [31:0] exp, input string what);
    logic [31:0] got;
    reg_read(idx, got);
    if (got !== exp) begin
      $display("ERROR %0t: %s reads %h, expected %h", $time, what, got, exp);
      err_cnt++;
    end
  endtask

  task automatic wait_done(input int bit_pos);
    logic [31:0] status;
    status = '0;
    while (status[bit_pos] !== 1'b1) begin
      reg_read(`MSG_REG_STATUS, status);
    end
  endtask

  task automatic start_store(input logic [31:0] base, input int count);
    st_exp_addr = base;
    st_seen = 0;
    reg_write(`MSG_REG_ST_BASE, base);
    reg_write(`MSG_REG_CTRL, {16'd0, count[14:0], 1'b1});
  endtask

  task automatic finish_store(input int count);
    wait_done(0);
    if (st_seen != count) begin
      $display("ERROR %0t: %0d store strobes, expected %0d", $time, st_seen, count);
      err_cnt++;
    end
  endtask

  task automatic start_load(input logic [31:0] base, input int count, input int mode);
    ld_exp_addr = base;
    ld_seen = 0;
    rsp_cnt = 0;
    rsp_mode = mode;
    reg_write(`MSG_REG_LD_BASE, base);
    reg_write(`MSG_REG_CTRL, {count[14:0], 1'b1, 16'd0});
  endtask

  task automatic finish_load(input int count, input int exp_pass, input int exp_fail,
                             input logic exp_order);
    wait_done(1);
    if (ld_seen != count) begin
      $display("ERROR %0t: %0d load strobes, expected %0d", $time, ld_seen, count);
      err_cnt++;
    end
    check_reg(`MSG_REG_PASS, 32'(exp_pass), "pass count");
    check_reg(`MSG_REG_FAIL, 32'(exp_fail), "fail count");
    // Store done stays set from the earlier store run
    check_reg(`MSG_REG_STATUS, {29'd0, exp_order, 2'b11}, "status");
  endtask

  initial begin
    logic [31:0] base;
    int          count;
    lfsr_state = 32'h3e33_ef72;
    arst_n = 1'b0;
    reg_wr = 1'b0;
    reg_idx = `MSG_REG_CTRL;
    reg_wdata = '0;
    back_pres = 3'd0;
    halt = 1'b0;
    rsp_valid = 1'b0;
    rsp_data = '0;
    rsp_tag = '0;
    err_cnt = 0;
    proto_err = 0;
    st_seen = 0;
    ld_seen = 0;
    rsp_cnt = 0;
    rsp_wait = 0;
    rsp_mode = MODE_CLEAN;
    halt_watch = 1'b0;
    st_exp_addr = '0;
    ld_exp_addr = '0;

    // Strobes stay low while reset is held and after its release
    for (int i = 0; i < 12; i++) begin
      @(negedge fabric_clk);
      if (st_valid !== 1'b0 || ld_valid !== 1'b0) begin
        $display("ERROR %0t: strobe active around reset", $time);
        err_cnt++;
      end
      if (i == 7) begin
        arst_n = 1'b1;
      end
    end
    check_reg(`MSG_REG_STATUS, 32'd0, "status after reset");
    check_reg(`MSG_REG_PASS, 32'd0, "pass count after reset");
    check_reg(`MSG_REG_FAIL, 32'd0, "fail count after reset");

    // Store, then clean, corrupted and reordered loads over the range
    base = take_bits(29) << 3;
    count = 8 + int'(take_bits(5));
    start_store(base, count);
    finish_store(count);
    start_load(base, count, MODE_CLEAN);
    finish_load(count, count, 0, 1'b0);
    start_load(base, count, MODE_CORRUPT);
    finish_load(count, count - 1, 1, 1'b0);
    start_load(base, count, MODE_SWAP);
    finish_load(count, count, 0, 1'b1);

    // Full back-pressure
    back_pres = 3'd7;
    base = take_bits(29) << 3;
    count = 8 + int'(take_bits(5));
    start_store(base, count);
    finish_store(count);
    start_load(base, count, MODE_CLEAN);
    finish_load(count, count, 0, 1'b0);
    back_pres = 3'd0;

    // Runs started under halt stay silent until release
    halt = 1'b1;
    base = take_bits(29) << 3;
    count = 8 + int'(take_bits(5));
    start_store(base, count);
    halt_watch = 1'b1;
    repeat (20) @(negedge fabric_clk);
    halt_watch = 1'b0;
    halt = 1'b0;
    finish_store(count);
    halt = 1'b1;
    start_load(base, count, MODE_CLEAN);
    halt_watch = 1'b1;
    repeat (20) @(negedge fabric_clk);
    halt_watch = 1'b0;
    halt = 1'b0;
    finish_load(count, count, 0, 1'b0);

    $display("Summary: %0d value errors, %0d protocol errors", err_cnt, proto_err);
    if (err_cnt == 0 && proto_err == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: list.f
+incdir+.
msg_pkg.sv
msg_throttle.sv
msg_regs.sv
msgst_engine.sv
msgld_engine.sv
msg_traffic_top.sv
tb_msg_traffic.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the message traffic testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -f list.f --top-module tb_msg_traffic \
    -o sim_tb > build.log 2>&1; then
  cat build.log
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
sim_status=$?
cat sim.log

if [ "$sim_status" -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q "TESTS FAILED" sim.log; then
  exit 1
fi

exit 0
